// ==== common/zx_bus_pkg.sv ====
// Z80 bus side definitions
// widths, I/O port addresses and the 7FFD register layout
`default_nettype none

package zx_bus_pkg;

	////////////////////////////////////////////////////////////
	// bus widths
	////////////////////////////////////////////////////////////

	localparam int addr_w   = 16;
	localparam int data_w   = 8;
	// offset inside one 16K window
	localparam int offset_w = 14;

	////////////////////////////////////////////////////////////
	// port addresses
	////////////////////////////////////////////////////////////

	// classic 128K memory port, full decode
	localparam logic [addr_w-1:0] port_7ffd = 16'h7FFD;

	// ATM ports, low byte only
	localparam logic [7:0] port_lo_f7 = 8'hF7;
	localparam logic [7:0] port_lo_77 = 8'h77;
	localparam logic [7:0] port_lo_be = 8'hBE;

	// opcode fetch here turns the shadow ROM on
	localparam logic [7:0] dos_trap_hi = 8'h3D;

	////////////////////////////////////////////////////////////
	// 7FFD register
	////////////////////////////////////////////////////////////

	typedef logic [data_w-1:0] p7ffd_t;

	localparam int p7ffd_lock_bit = 5;
	localparam int p7ffd_rom_bit  = 4;

endpackage

`default_nettype wire

// ==== common/zx_map_pkg.sv ====
// memory map definitions
// window and page types, and the page word stored by the ATM pagers
`default_nettype none

package zx_map_pkg;

	// four 16K windows in the Z80 address space
	localparam int win_count = 4;

	typedef logic [1:0] win_idx_t;
	// variant bit above the window index
	typedef logic [2:0] reg_idx_t;

	typedef logic [6:0] ram_page_t;
	typedef logic [4:0] rom_bank_t;

	////////////////////////////////////////////////////////////
	// page word, one byte read two ways
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic      is_ram;
		ram_page_t page;
	} page_ram_t;

	typedef struct packed {
		logic      is_ram;
		logic      spare;
		// bank bit 0 follows the inverted dos flag
		logic      follow_dos;
		rom_bank_t bank;
	} page_rom_t;

	typedef union packed {
		page_ram_t ram;
		page_rom_t rom;
	} page_word_u;

	// RAM page 0
	localparam page_word_u page_reset_word = 8'h80;

endpackage

`default_nettype wire

// ==== common/pager_cfg_if.sv ====
// page port writes and paging mode levels
// from the port decoder to the window pagers
`timescale 1ns/1ps
`default_nettype none

interface pager_cfg_if;

	// one cycle strobe for an xxF7 write
	logic                   page_wr;
	zx_map_pkg::win_idx_t   win;
	zx_map_pkg::page_word_u word;
	// 7FFD rom select at the time of the write
	logic                   variant;

	// levels
	logic                   pager_off;
	zx_bus_pkg::p7ffd_t     p7ffd;

	modport source (output page_wr, win, word, variant, pager_off, p7ffd);
	modport sink   (input  page_wr, win, word, variant, pager_off, p7ffd);

endinterface

`default_nettype wire

// ==== common/window_map_if.sv ====
// per-window mapping and readback registers
// pagers drive it, dos controller adds the dos flag
`timescale 1ns/1ps
`default_nettype none

interface window_map_if;

	logic                   is_rom   [zx_map_pkg::win_count];
	zx_map_pkg::rom_bank_t  rom_bank [zx_map_pkg::win_count];
	zx_map_pkg::ram_page_t  ram_page [zx_map_pkg::win_count];

	// raw page words, index {variant, window}
	zx_map_pkg::page_word_u regs [2*zx_map_pkg::win_count];

	// shadow ROM active
	logic                   dos_on;

	modport pager (output is_rom, rom_bank, ram_page, regs, input dos_on);
	modport dos   (output dos_on, input is_rom);
	modport user  (input is_rom, rom_bank, ram_page, regs, dos_on);

endinterface

`default_nettype wire

// ==== paging/atm_pager.sv ====
// ATM pager for one 16K window
// two page words selected by 7FFD rom bit, fixed 128K map when pager is off
`timescale 1ns/1ps
`default_nettype none

module atm_pager
#(
	parameter int window = 0
)
(
	input  logic         fclk,
	input  logic         reset,
	pager_cfg_if.sink    cfg,
	window_map_if.pager  map
);

	// index 0 and 1 are the two variants
	zx_map_pkg::page_word_u page_q [2];

	zx_map_pkg::page_word_u cur;
	logic                   is_rom_c;
	zx_map_pkg::rom_bank_t  bank_c;
	zx_map_pkg::ram_page_t  page_c;
	logic                   rom_sel;

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			page_q[0] <= zx_map_pkg::page_reset_word;
			page_q[1] <= zx_map_pkg::page_reset_word;
		end
		else if (cfg.page_wr && cfg.win == zx_map_pkg::win_idx_t'(window))
		begin
			page_q[cfg.variant] <= cfg.word;
		end
	end

	assign rom_sel = cfg.p7ffd[zx_bus_pkg::p7ffd_rom_bit];
	assign cur     = page_q[rom_sel];

	////////////////////////////////////////////////////////////
	// mapping
	////////////////////////////////////////////////////////////

	always_comb
	begin
		is_rom_c = 1'b0;
		bank_c   = '0;
		page_c   = '0;
		if (cfg.pager_off)
		begin
			// plain 128K layout
			case (window)
				0:
				begin
					is_rom_c = 1'b1;
					bank_c   = map.dos_on ? 5'd2 : {4'd0, rom_sel};
				end
				1:       page_c = 7'd5;
				2:       page_c = 7'd2;
				default: page_c = {4'd0, cfg.p7ffd[2:0]};
			endcase
		end
		else
		begin
			is_rom_c = !cur.ram.is_ram;
			page_c   = cur.ram.page;
			bank_c   = cur.rom.bank;
			// dos-tracking ROM pair
			if (cur.rom.follow_dos)
				bank_c[0] = !map.dos_on;
		end
	end

	assign map.is_rom[window]   = is_rom_c;
	assign map.rom_bank[window] = bank_c;
	assign map.ram_page[window] = page_c;

	// readback at {variant, window}
	assign map.regs[window]                         = page_q[0];
	assign map.regs[window + zx_map_pkg::win_count] = page_q[1];

endmodule

`default_nettype wire

// ==== paging/dos_control.sv ====
// shadow DOS ROM flag
// on at a 3Dxx fetch from ROM, off at any fetch from 4000 up
`timescale 1ns/1ps
`default_nettype none

module dos_control
(
	input  logic                          fclk,
	input  logic                          reset,
	input  logic                          mem_rd,
	input  logic                          m1,
	input  logic [zx_bus_pkg::addr_w-1:0] a,
	window_map_if.dos                     map
);

	logic fetch;
	logic dos_q;

	assign fetch = mem_rd && m1;

	always_ff @(posedge fclk)
	begin
		if (reset)
			dos_q <= 1'b0;
		else if (fetch && a[15:8] == zx_bus_pkg::dos_trap_hi && map.is_rom[0])
			dos_q <= 1'b1;
		else if (fetch && a[15:14] != 2'b00)
			dos_q <= 1'b0;
	end

	assign map.dos_on = dos_q;

endmodule

`default_nettype wire

// ==== design/port_decoder.sv ====
// I/O port decoder for the paging ports
// 7FFD, xx77 config, xxF7 page writes and xxBE page readback
`timescale 1ns/1ps
`default_nettype none

module port_decoder
(
	input  logic                          fclk,
	input  logic                          reset,
	input  logic [zx_bus_pkg::addr_w-1:0] a,
	input  logic [zx_bus_pkg::data_w-1:0] d_in,
	input  logic                          io_wr,
	input  logic                          io_rd,
	pager_cfg_if.source                   cfg,
	window_map_if.user                    map,
	output logic                          romrw_en,
	output logic [zx_bus_pkg::data_w-1:0] d_out,
	output logic                          d_ena
);

	zx_bus_pkg::p7ffd_t   p7ffd_q;
	logic                 pager_off_q;
	logic                 hit_7ffd;
	logic                 hit_77;
	logic                 hit_f7;
	logic                 hit_be;
	zx_map_pkg::reg_idx_t rd_idx;

	assign hit_7ffd = (a == zx_bus_pkg::port_7ffd);
	assign hit_77   = (a[7:0] == zx_bus_pkg::port_lo_77);
	assign hit_f7   = (a[7:0] == zx_bus_pkg::port_lo_f7);
	assign hit_be   = (a[7:0] == zx_bus_pkg::port_lo_be);

	////////////////////////////////////////////////////////////
	// config registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			p7ffd_q     <= '0;
			pager_off_q <= 1'b1;
			romrw_en    <= 1'b0;
		end
		else if (io_wr)
		begin
			// frozen once locked, only reset clears it
			if (hit_7ffd && !p7ffd_q[zx_bus_pkg::p7ffd_lock_bit])
				p7ffd_q <= d_in;
			if (hit_77)
			begin
				pager_off_q <= !d_in[0];
				romrw_en    <= d_in[1];
			end
		end
	end

	// page write goes straight to the pagers
	assign cfg.page_wr   = io_wr && hit_f7;
	assign cfg.win       = a[15:14];
	assign cfg.word      = d_in;
	assign cfg.variant   = p7ffd_q[zx_bus_pkg::p7ffd_rom_bit];
	assign cfg.pager_off = pager_off_q;
	assign cfg.p7ffd     = p7ffd_q;

	////////////////////////////////////////////////////////////
	// xxBE readback
	////////////////////////////////////////////////////////////

	// a[10] picks the variant, a[9:8] the window
	assign rd_idx = a[10:8];

	always_ff @(posedge fclk)
	begin
		if (reset)
			d_ena <= 1'b0;
		else
			d_ena <= io_rd && hit_be;
	end

	always_ff @(posedge fclk)
	begin
		if (io_rd && hit_be)
			d_out <= map.regs[rd_idx];
	end

endmodule

`default_nettype wire

// ==== design/mem_mapper.sv ====
// memory access translation
// window select from a[15:14], ROM bank or RAM page plus offset, one cycle
`timescale 1ns/1ps
`default_nettype none

module mem_mapper
(
	input  logic                            fclk,
	input  logic                            reset,
	input  logic [zx_bus_pkg::addr_w-1:0]   a,
	input  logic                            mem_rd,
	input  logic                            mem_wr,
	input  logic                            romrw_en,
	window_map_if.user                      map,
	output logic                            mem_valid,
	output logic                            mem_rom,
	output zx_map_pkg::ram_page_t           mem_page,
	output logic [zx_bus_pkg::offset_w-1:0] mem_offset,
	output logic                            mem_we
);

	zx_map_pkg::win_idx_t  win;
	logic                  rom_c;
	zx_map_pkg::ram_page_t page_c;

	assign win    = a[15:14];
	assign rom_c  = map.is_rom[win];
	// ROM bank zero-extended to the page width
	assign page_c = rom_c ? {2'b00, map.rom_bank[win]} : map.ram_page[win];

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			mem_valid <= 1'b0;
			mem_we    <= 1'b0;
		end
		else
		begin
			mem_valid <= mem_rd || mem_wr;
			// ROM writes only with xx77 bit 1
			mem_we    <= mem_wr && (!rom_c || romrw_en);
		end
	end

	always_ff @(posedge fclk)
	begin
		mem_rom    <= rom_c;
		mem_page   <= page_c;
		mem_offset <= a[zx_bus_pkg::offset_w-1:0];
	end

endmodule

`default_nettype wire

// ==== design/zx_mem_top.sv ====
// memory paging core top level
// port decoder, four window pagers, dos controller and mapper
`timescale 1ns/1ps
`default_nettype none

module zx_mem_top
(
	input  logic                            fclk,
	input  logic                            reset,

	// z80 side, one cycle strobes
	input  logic [zx_bus_pkg::addr_w-1:0]   a,
	input  logic [zx_bus_pkg::data_w-1:0]   d_in,
	input  logic                            io_wr,
	input  logic                            io_rd,
	input  logic                            mem_rd,
	input  logic                            mem_wr,
	input  logic                            m1,

	output logic [zx_bus_pkg::data_w-1:0]   d_out,
	output logic                            d_ena,

	// translated access
	output logic                            mem_valid,
	output logic                            mem_rom,
	output zx_map_pkg::ram_page_t           mem_page,
	output logic [zx_bus_pkg::offset_w-1:0] mem_offset,
	output logic                            mem_we,

	output logic                            dos
);

	logic romrw_en;

	pager_cfg_if  cfg_if ();
	window_map_if map_if ();

	////////////////////////////////////////////////////////////
	// I/O ports
	////////////////////////////////////////////////////////////

	port_decoder u_ports
	(
		.fclk    (fclk    ),
		.reset   (reset   ),
		.a       (a       ),
		.d_in    (d_in    ),
		.io_wr   (io_wr   ),
		.io_rd   (io_rd   ),
		.cfg     (cfg_if  ),
		.map     (map_if  ),
		.romrw_en(romrw_en),
		.d_out   (d_out   ),
		.d_ena   (d_ena   )
	);

	////////////////////////////////////////////////////////////
	// window pagers
	////////////////////////////////////////////////////////////

	for (genvar w = 0; w < zx_map_pkg::win_count; w++)
	begin : g_pager
		atm_pager #(.window(w)) u_pager
		(
			.fclk (fclk  ),
			.reset(reset ),
			.cfg  (cfg_if),
			.map  (map_if)
		);
	end

	dos_control u_dos
	(
		.fclk  (fclk  ),
		.reset (reset ),
		.mem_rd(mem_rd),
		.m1    (m1    ),
		.a     (a     ),
		.map   (map_if)
	);

	mem_mapper u_mapper
	(
		.fclk      (fclk      ),
		.reset     (reset     ),
		.a         (a         ),
		.mem_rd    (mem_rd    ),
		.mem_wr    (mem_wr    ),
		.romrw_en  (romrw_en  ),
		.map       (map_if    ),
		.mem_valid (mem_valid ),
		.mem_rom   (mem_rom   ),
		.mem_page  (mem_page  ),
		.mem_offset(mem_offset),
		.mem_we    (mem_we    )
	);

	assign dos = map_if.dos_on;

endmodule

`default_nettype wire

// ==== testbench/zx_mem_assertions.sv ====
// timing checks on the memory paging core
// bound to the top level
`timescale 1ns/1ps
`default_nettype none

module zx_mem_assertions
(
	input logic                          fclk,
	input logic                          reset,
	input logic [zx_bus_pkg::addr_w-1:0] a,
	input logic                          io_rd,
	input logic                          mem_rd,
	input logic                          mem_wr,
	input logic                          mem_valid,
	input logic                          mem_we,
	input logic                          d_ena
);

	logic be_read;

	assign be_read = io_rd && (a[7:0] == zx_bus_pkg::port_lo_be);

	// one result per strobe, one cycle later
	valid_follows_strobe: assert property (@(posedge fclk) disable iff (reset)
		mem_valid == $past(mem_rd || mem_wr))
		else $error("mem_valid does not follow the memory strobe");

	// write enable only for a write strobe one cycle back
	we_needs_valid: assert property (@(posedge fclk) disable iff (reset)
		mem_we |-> mem_valid && $past(mem_wr))
		else $error("mem_we without a write access");

	readback_one_cycle: assert property (@(posedge fclk) disable iff (reset)
		d_ena == $past(be_read))
		else $error("d_ena does not match the xxBE read");

	quiet_in_reset: assert property (@(posedge fclk)
		reset |=> (!mem_valid && !mem_we && !d_ena))
		else $error("outputs active during reset");

endmodule

bind zx_mem_top zx_mem_assertions u_assertions
(
	.fclk     (fclk     ),
	.reset    (reset    ),
	.a        (a        ),
	.io_rd    (io_rd    ),
	.mem_rd   (mem_rd   ),
	.mem_wr   (mem_wr   ),
	.mem_valid(mem_valid),
	.mem_we   (mem_we   ),
	.d_ena    (d_ena    )
);

`default_nettype wire

// ==== testbench/tb_zx_mem_top.sv ====
// testbench for the memory paging core
// directed port and memory access tests checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_zx_mem_top;

	// the tests take about 200 cycles
	localparam int timeout_cycles = 2000;

	logic                            fclk;
	logic                            reset;
	logic [zx_bus_pkg::addr_w-1:0]   a;
	logic [zx_bus_pkg::data_w-1:0]   d_in;
	logic                            io_wr;
	logic                            io_rd;
	logic                            mem_rd;
	logic                            mem_wr;
	logic                            m1;
	logic [zx_bus_pkg::data_w-1:0]   d_out;
	logic                            d_ena;
	logic                            mem_valid;
	logic                            mem_rom;
	zx_map_pkg::ram_page_t           mem_page;
	logic [zx_bus_pkg::offset_w-1:0] mem_offset;
	logic                            mem_we;
	logic                            dos;

	// reference model state
	zx_bus_pkg::p7ffd_t     p7ffd_m;
	logic                   pager_off_m;
	logic                   romrw_m;
	logic                   dos_m;
	zx_map_pkg::page_word_u regs_m [2*zx_map_pkg::win_count];

	int cycle_count = 0;

	zx_mem_top UUT
	(
		.fclk      (fclk      ),
		.reset     (reset     ),
		.a         (a         ),
		.d_in      (d_in      ),
		.io_wr     (io_wr     ),
		.io_rd     (io_rd     ),
		.mem_rd    (mem_rd    ),
		.mem_wr    (mem_wr    ),
		.m1        (m1        ),
		.d_out     (d_out     ),
		.d_ena     (d_ena     ),
		.mem_valid (mem_valid ),
		.mem_rom   (mem_rom   ),
		.mem_page  (mem_page  ),
		.mem_offset(mem_offset),
		.mem_we    (mem_we    ),
		.dos       (dos       )
	);

	always #5 fclk = ~fclk;

	always @(posedge fclk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			fail_run("timeout, the tests did not finish in time");
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic cur_variant();
		return p7ffd_m[zx_bus_pkg::p7ffd_rom_bit];
	endfunction

	function automatic logic model_is_rom(input zx_map_pkg::win_idx_t w);
		zx_map_pkg::page_word_u word;
		word = regs_m[{cur_variant(), w}];
		if (pager_off_m)
			return (w == 2'd0);
		return !word.ram.is_ram;
	endfunction

	function automatic zx_map_pkg::ram_page_t model_page(input zx_map_pkg::win_idx_t w);
		zx_map_pkg::page_word_u word;
		zx_map_pkg::rom_bank_t  bank;
		word = regs_m[{cur_variant(), w}];
		bank = word.rom.bank;
		if (pager_off_m)
		begin
			case (w)
				2'd0:    return dos_m ? 7'd2 : {6'd0, cur_variant()};
				2'd1:    return 7'd5;
				2'd2:    return 7'd2;
				default: return {4'd0, p7ffd_m[2:0]};
			endcase
		end
		if (word.ram.is_ram)
			return word.ram.page;
		// dos picks the even bank of the pair
		if (word.rom.follow_dos)
			bank[0] = !dos_m;
		return {2'd0, bank};
	endfunction

	function automatic logic [15:0] win_addr(input zx_map_pkg::win_idx_t w);
		logic [13:0] off;
		off = 14'($urandom());
		return {w, off};
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_byte(input zx_map_pkg::page_word_u exp);
		if (d_out !== exp)
			fail_run($sformatf("FAIL d_out got 0x%02h expected 0x%02h", d_out, exp));
	endtask

	task automatic check_map(input logic exp_rom, input zx_map_pkg::ram_page_t exp_page,
		input logic [zx_bus_pkg::offset_w-1:0] exp_offset);
		check_bit("mem_rom", mem_rom, exp_rom);
		if (mem_page !== exp_page)
			fail_run($sformatf("FAIL mem_page got 0x%02h expected 0x%02h",
				mem_page, exp_page));
		if (mem_offset !== exp_offset)
			fail_run($sformatf("FAIL mem_offset got 0x%04h expected 0x%04h",
				mem_offset, exp_offset));
	endtask

	////////////////////////////////////////////////////////////
	// bus tasks
	////////////////////////////////////////////////////////////

	task automatic hold_reset();
		reset <= 1'b1;
		repeat (3) @(posedge fclk);
		reset <= 1'b0;
		p7ffd_m     = '0;
		pager_off_m = 1'b1;
		romrw_m     = 1'b0;
		dos_m       = 1'b0;
		for (int i = 0; i < 2*zx_map_pkg::win_count; i++)
			regs_m[i] = zx_map_pkg::page_reset_word;
	endtask

	task automatic wait_mem_valid();
		@(negedge fclk);
		while (!mem_valid)
			@(negedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge fclk);
		a     <= addr;
		d_in  <= data;
		io_wr <= 1'b1;
		@(posedge fclk);
		io_wr <= 1'b0;
		// page word goes to the variant before this write
		if (addr[7:0] == zx_bus_pkg::port_lo_f7)
			regs_m[{cur_variant(), addr[15:14]}] = data;
		if (addr == zx_bus_pkg::port_7ffd && !p7ffd_m[zx_bus_pkg::p7ffd_lock_bit])
			p7ffd_m = data;
		if (addr[7:0] == zx_bus_pkg::port_lo_77)
		begin
			pager_off_m = !data[0];
			romrw_m     = data[1];
		end
	endtask

	task automatic io_read(input zx_map_pkg::reg_idx_t idx);
		@(posedge fclk);
		a     <= {5'd0, idx, zx_bus_pkg::port_lo_be};
		io_rd <= 1'b1;
		@(posedge fclk);
		io_rd <= 1'b0;
		@(negedge fclk);
		while (!d_ena)
			@(negedge fclk);
		check_byte(regs_m[idx]);
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic write);
		logic                  exp_rom;
		zx_map_pkg::ram_page_t exp_page;
		exp_rom  = model_is_rom(addr[15:14]);
		exp_page = model_page(addr[15:14]);
		@(posedge fclk);
		a      <= addr;
		mem_rd <= !write;
		mem_wr <= write;
		@(posedge fclk);
		mem_rd <= 1'b0;
		mem_wr <= 1'b0;
		wait_mem_valid();
		check_map(exp_rom, exp_page, addr[13:0]);
		check_bit("mem_we", mem_we, write && (!exp_rom || romrw_m));
	endtask

	task automatic fetch(input logic [15:0] addr);
		logic                  exp_rom;
		zx_map_pkg::ram_page_t exp_page;
		logic                  trap;
		exp_rom  = model_is_rom(addr[15:14]);
		exp_page = model_page(addr[15:14]);
		trap     = (addr[15:8] == zx_bus_pkg::dos_trap_hi) && model_is_rom(2'd0);
		@(posedge fclk);
		a      <= addr;
		mem_rd <= 1'b1;
		m1     <= 1'b1;
		@(posedge fclk);
		mem_rd <= 1'b0;
		m1     <= 1'b0;
		wait_mem_valid();
		check_map(exp_rom, exp_page, addr[13:0]);
		if (trap)
			dos_m = 1'b1;
		else if (addr[15:14] != 2'b00)
			dos_m = 1'b0;
		check_bit("dos", dos, dos_m);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_mapping();
		@(negedge fclk);
		check_bit("d_ena", d_ena, 1'b0);
		check_bit("dos", dos, 1'b0);
		for (int w = 0; w < zx_map_pkg::win_count; w++)
			mem_access(win_addr(zx_map_pkg::win_idx_t'(w)), 1'b0);
	endtask

	task automatic p7ffd_paging();
		// rom 1, page 3, then rom 0, page 4
		io_write(zx_bus_pkg::port_7ffd, 8'h13);
		for (int w = 0; w < zx_map_pkg::win_count; w++)
			mem_access(win_addr(zx_map_pkg::win_idx_t'(w)), 1'b0);
		io_write(zx_bus_pkg::port_7ffd, 8'h04);
		mem_access(win_addr(2'd0), 1'b0);
		mem_access(win_addr(2'd3), 1'b0);
	endtask

	task automatic atm_paging();
		zx_map_pkg::page_word_u word;
		io_write(16'h0077, 8'h01);
		for (int v = 0; v < 2; v++)
		begin
			io_write(zx_bus_pkg::port_7ffd, v[0] ? 8'h10 : 8'h00);
			for (int w = 0; w < zx_map_pkg::win_count; w++)
			begin
				word.ram.is_ram = 1'b1;
				word.ram.page   = 7'(32*v + 4*w + 9);
				io_write({zx_map_pkg::win_idx_t'(w), 6'd0, zx_bus_pkg::port_lo_f7}, word);
				mem_access(win_addr(zx_map_pkg::win_idx_t'(w)), 1'b0);
				mem_access(win_addr(zx_map_pkg::win_idx_t'(w)), 1'b1);
				word                = '0;
				word.rom.follow_dos = v[0] ^ w[0];
				word.rom.bank       = 5'(8*v + 2*w + 1);
				io_write({zx_map_pkg::win_idx_t'(w), 6'd0, zx_bus_pkg::port_lo_f7}, word);
				mem_access(win_addr(zx_map_pkg::win_idx_t'(w)), 1'b0);
			end
		end
		// variant 1 has follow_dos in windows 0 and 2
		fetch(16'h3D05);
		mem_access(win_addr(2'd0), 1'b0);
		mem_access(win_addr(2'd2), 1'b0);
		fetch(16'hC000);
		mem_access(win_addr(2'd0), 1'b0);
		io_write(zx_bus_pkg::port_7ffd, 8'h00);
		for (int w = 0; w < zx_map_pkg::win_count; w++)
			mem_access(win_addr(zx_map_pkg::win_idx_t'(w)), 1'b0);
	endtask

	task automatic page_readback();
		io_write(16'h40F7, 8'hA3);
		io_write(16'hC0F7, 8'hFE);
		for (int i = 0; i < 2*zx_map_pkg::win_count; i++)
			io_read(zx_map_pkg::reg_idx_t'(i));
	endtask

	task automatic dos_switching();
		// window 0 in RAM, no trap
		io_write(16'h00F7, 8'h87);
		fetch(16'h3D10);
		io_write(16'h0077, 8'h00);
		fetch(16'h3D2F);
		mem_access(win_addr(2'd0), 1'b0);
		fetch(16'h0100);
		fetch(16'h4123);
		mem_access(win_addr(2'd0), 1'b0);
	endtask

	task automatic rom_write_protect();
		mem_access(16'h1234, 1'b1);
		mem_access(16'h8765, 1'b1);
		io_write(16'h0077, 8'h02);
		mem_access(16'h1234, 1'b1);
		mem_access(16'hC001, 1'b1);
		io_write(16'h0077, 8'h00);
		mem_access(16'h2000, 1'b1);
	endtask

	task automatic p7ffd_lock();
		io_write(zx_bus_pkg::port_7ffd, 8'h26);
		mem_access(win_addr(2'd3), 1'b0);
		io_write(zx_bus_pkg::port_7ffd, 8'h17);
		mem_access(win_addr(2'd0), 1'b0);
		mem_access(win_addr(2'd3), 1'b0);
		// reset clears the lock
		@(posedge fclk);
		hold_reset();
		io_write(zx_bus_pkg::port_7ffd, 8'h01);
		mem_access(win_addr(2'd3), 1'b0);
	endtask

	initial
	begin
		fclk   = 1'b0;
		reset  = 1'b1;
		a      = '0;
		d_in   = '0;
		io_wr  = 1'b0;
		io_rd  = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		m1     = 1'b0;
		void'($urandom(97));
		hold_reset();
		reset_mapping();
		p7ffd_paging();
		atm_paging();
		page_readback();
		dos_switching();
		rom_write_protect();
		p7ffd_lock();
		@(posedge fclk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== zx_mem_top.f ====
common/zx_bus_pkg.sv
common/zx_map_pkg.sv
common/pager_cfg_if.sv
common/window_map_if.sv
paging/atm_pager.sv
paging/dos_control.sv
design/port_decoder.sv
design/mem_mapper.sv
design/zx_mem_top.sv
testbench/zx_mem_assertions.sv
testbench/tb_zx_mem_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory paging testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert \
	-f zx_mem_top.f \
	--top-module tb_zx_mem_top \
	-Mdir "$build"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build/Vtb_zx_mem_top" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
	echo "failure reported in $log"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation passed"
exit 0
